// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  // ------------------------------------------------------------------------
  // Scalar types
  // ------------------------------------------------------------------------

  // Instruction address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // AXI4 read channel fields
  typedef logic [3:0] axi_id_t;
  typedef logic [1:0] axi_resp_t;

  // RRESP encodings
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_EXOKAY = 2'd1;
  localparam axi_resp_t RESP_SLVERR = 2'd2;
  localparam axi_resp_t RESP_DECERR = 2'd3;

  // Fetch error code carried to decode
  typedef logic [1:0] fetch_err_t;

  localparam fetch_err_t ERR_NONE    = 2'd0;
  localparam fetch_err_t ERR_BUS     = 2'd1;
  localparam fetch_err_t ERR_ID      = 2'd2;
  localparam fetch_err_t ERR_NO_LAST = 2'd3;

  // ------------------------------------------------------------------------
  // Records
  // ------------------------------------------------------------------------

  // One R beat as seen on the bus, 39 bits
  typedef struct packed {
    inst_t     data;
    axi_resp_t resp;
    logic      last;
    axi_id_t   id;
  } read_beat_t;

  // Request side record, 36 bits
  typedef struct packed {
    addr_t   pc;
    axi_id_t id;
  } fetch_req_t;

  // Packet handed to decode, 66 bits
  typedef struct packed {
    addr_t      pc;
    inst_t      inst;
    fetch_err_t err;
  } fetch_packet_t;

endpackage

// ==== hw/fetch_controller.sv ====
`timescale 1ns/1ns

module fetch_controller (
  input  logic clock,
  input  logic reset,

  // Upstream PC handshake
  input  logic pc_valid_i,
  output logic pc_ready_o,

  // AR channel handshake
  input  logic arready_i,
  output logic arvalid_o,

  // R channel handshake
  input  logic rvalid_i,
  output logic rready_o,

  // Downstream packet handshake
  input  logic pkt_ready_i,
  output logic pkt_valid_o,

  // Strobes to the datapath
  output logic pc_we_o,
  output logic ar_done_o,
  output logic beat_we_o
);

  // One fetch in flight, walked through four states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_HANDOFF
  } fetch_state_e;

  fetch_state_e cur_state;
  fetch_state_e next_state;

  // --------------------------------------------------------------------------
  // Handshake outputs, straight state decode
  // --------------------------------------------------------------------------

  assign pc_ready_o  = (cur_state == ST_IDLE);
  assign arvalid_o   = (cur_state == ST_ADDR);
  assign rready_o    = (cur_state == ST_DATA);
  assign pkt_valid_o = (cur_state == ST_HANDOFF);

  // Strobes fire in the same cycle as each handshake
  assign pc_we_o   = pc_valid_i & pc_ready_o;
  assign ar_done_o = arvalid_o & arready_i;
  assign beat_we_o = rvalid_i & rready_o;

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      cur_state <= ST_IDLE;
    end else begin
      cur_state <= next_state;
    end
  end

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    // Hold by default, each wait state spins under back-pressure
    next_state = cur_state;
    case (cur_state)
      ST_IDLE: begin
        // PC accepted, issue the read next
        if (pc_we_o) begin
          next_state = ST_ADDR;
        end
      end
      ST_ADDR: begin
        // Address taken by the slave
        if (ar_done_o) begin
          next_state = ST_DATA;
        end
      end
      ST_DATA: begin
        // Single beat captured
        if (beat_we_o) begin
          next_state = ST_HANDOFF;
        end
      end
      ST_HANDOFF: begin
        // Decode took the packet
        if (pkt_ready_i) begin
          next_state = ST_IDLE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

endmodule

// ==== hw/fetch_request.sv ====
`timescale 1ns/1ns

module fetch_request (
  input  logic                 clock,
  input  logic                 reset,

  // PC load from the upstream handshake
  input  logic                 pc_we_i,
  input  fetch_pkg::addr_t     pc_i,

  // AR handshake seen by the controller
  input  logic                 ar_done_i,

  // AR channel fields
  output fetch_pkg::addr_t     araddr_o,
  output fetch_pkg::axi_id_t   arid_o,

  // Record for the packer
  output fetch_pkg::fetch_req_t req_o
);

  fetch_pkg::addr_t   pc_q;
  fetch_pkg::axi_id_t id_cnt_q;
  fetch_pkg::axi_id_t issued_id_q;

  // --------------------------------------------------------------------------
  // PC register
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      pc_q <= '0;
    end else if (pc_we_i) begin
      pc_q <= pc_i;
    end
  end

  // --------------------------------------------------------------------------
  // Rolling transaction ID
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      id_cnt_q    <= '0;
      issued_id_q <= '0;
    end else if (ar_done_i) begin
      // Keep the ID that went out, then move on
      issued_id_q <= id_cnt_q;
      // Wraps at 16 by width
      id_cnt_q    <= id_cnt_q + 1'b1;
    end
  end

  // AR fields stay stable while arvalid waits
  assign araddr_o = pc_q;
  assign arid_o   = id_cnt_q;

  // PC paired with the ID actually issued
  assign req_o.pc = pc_q;
  assign req_o.id = issued_id_q;

endmodule

// ==== hw/read_capture.sv ====
`timescale 1ns/1ns

module read_capture (
  input  logic                  clock,
  input  logic                  reset,

  // Load strobe, high on the R handshake
  input  logic                  beat_we_i,

  // Beat as presented on the R channel
  input  fetch_pkg::read_beat_t beat_i,

  // Held copy for the packer
  output fetch_pkg::read_beat_t beat_o
);

  fetch_pkg::read_beat_t beat_q;

  // --------------------------------------------------------------------------
  // Beat register
  // --------------------------------------------------------------------------

  // The slave may drop rvalid and change the bus right after the handshake,
  // while decode can still stall the packet for many cycles
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      beat_q <= '0;
    end else if (beat_we_i) begin
      beat_q <= beat_i;
    end
  end

  // Whole record forwarded, fields picked apart in the packer
  assign beat_o = beat_q;

endmodule

// ==== hw/fetch_packer.sv ====
`timescale 1ns/1ns

module fetch_packer (
  // Request record from the address side
  input  fetch_pkg::fetch_req_t    req_i,

  // Captured beat from the data side
  input  fetch_pkg::read_beat_t    beat_i,

  // Packet for decode
  output fetch_pkg::fetch_packet_t pkt_o
);

  fetch_pkg::fetch_err_t err;

  // --------------------------------------------------------------------------
  // Error code, first match wins
  // --------------------------------------------------------------------------

  always_comb begin
    if (beat_i.resp == fetch_pkg::RESP_SLVERR ||
        beat_i.resp == fetch_pkg::RESP_DECERR) begin
      // Bus error masks anything else
      err = fetch_pkg::ERR_BUS;
    end else if (beat_i.id != req_i.id) begin
      // Beat belongs to some other transaction
      err = fetch_pkg::ERR_ID;
    end else if (!beat_i.last) begin
      // Single-beat read must end here
      err = fetch_pkg::ERR_NO_LAST;
    end else begin
      // OKAY and EXOKAY both land here
      err = fetch_pkg::ERR_NONE;
    end
  end

  // Packet fields
  assign pkt_o.pc   = req_i.pc;
  assign pkt_o.inst = beat_i.data;
  assign pkt_o.err  = err;

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
  input  logic                     clock,
  input  logic                     reset,

  // Upstream PC
  input  logic                     pc_valid_i,
  input  fetch_pkg::addr_t         pc_i,
  output logic                     pc_ready_o,

  // AXI4 AR channel
  output logic                     arvalid_o,
  input  logic                     arready_i,
  output fetch_pkg::addr_t         araddr_o,
  output fetch_pkg::axi_id_t       arid_o,

  // AXI4 R channel
  input  logic                     rvalid_i,
  output logic                     rready_o,
  input  fetch_pkg::inst_t         rdata_i,
  input  fetch_pkg::axi_resp_t     rresp_i,
  input  logic                     rlast_i,
  input  fetch_pkg::axi_id_t       rid_i,

  // Decode side
  output logic                     pkt_valid_o,
  input  logic                     pkt_ready_i,
  output fetch_pkg::fetch_packet_t pkt_o
);

  // Controller strobes
  logic pc_we;
  logic ar_done;
  logic beat_we;

  // Datapath records
  fetch_pkg::read_beat_t r_beat;
  fetch_pkg::read_beat_t beat_q;
  fetch_pkg::fetch_req_t req;

  // R fields gathered into one beat
  assign r_beat = '{data: rdata_i, resp: rresp_i, last: rlast_i, id: rid_i};

  // --------------------------------------------------------------------------
  // Sequencing
  // --------------------------------------------------------------------------

  fetch_controller u_controller (
    .clock       (clock),
    .reset       (reset),
    .pc_valid_i  (pc_valid_i),
    .pc_ready_o  (pc_ready_o),
    .arready_i   (arready_i),
    .arvalid_o   (arvalid_o),
    .rvalid_i    (rvalid_i),
    .rready_o    (rready_o),
    .pkt_ready_i (pkt_ready_i),
    .pkt_valid_o (pkt_valid_o),
    .pc_we_o     (pc_we),
    .ar_done_o   (ar_done),
    .beat_we_o   (beat_we)
  );

  // --------------------------------------------------------------------------
  // Request and capture sides
  // --------------------------------------------------------------------------

  fetch_request u_request (
    .clock     (clock),
    .reset     (reset),
    .pc_we_i   (pc_we),
    .pc_i      (pc_i),
    .ar_done_i (ar_done),
    .araddr_o  (araddr_o),
    .arid_o    (arid_o),
    .req_o     (req)
  );

  read_capture u_capture (
    .clock     (clock),
    .reset     (reset),
    .beat_we_i (beat_we),
    .beat_i    (r_beat),
    .beat_o    (beat_q)
  );

  // Packet assembly
  fetch_packer u_packer (
    .req_i  (req),
    .beat_i (beat_q),
    .pkt_o  (pkt_o)
  );

endmodule

// ==== sim/tb_fetch_unit.sv ====
`timescale 1ns/1ns

module tb_fetch_unit;

  // Wait limit in clock cycles
  localparam int TIMEOUT = 50;

  logic                     clock;
  logic                     reset;
  logic                     pc_valid_i;
  fetch_pkg::addr_t         pc_i;
  logic                     pc_ready_o;
  logic                     arvalid_o;
  logic                     arready_i;
  fetch_pkg::addr_t         araddr_o;
  fetch_pkg::axi_id_t       arid_o;
  logic                     rvalid_i;
  logic                     rready_o;
  fetch_pkg::inst_t         rdata_i;
  fetch_pkg::axi_resp_t     rresp_i;
  logic                     rlast_i;
  fetch_pkg::axi_id_t       rid_i;
  logic                     pkt_valid_o;
  logic                     pkt_ready_i;
  fetch_pkg::fetch_packet_t pkt_o;

  int                 errors = 0;
  int unsigned        cycle_cnt = 0;
  // Model of the rolling AR ID
  fetch_pkg::axi_id_t exp_id = '0;

  fetch_unit u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------------------------------
  // Compare helpers
  // --------------------------------------------------------------------------

  task automatic compare_addr(input string name, input fetch_pkg::addr_t exp,
                              input fetch_pkg::addr_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_id(input string name, input fetch_pkg::axi_id_t exp,
                            input fetch_pkg::axi_id_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_packet(input string name, input fetch_pkg::fetch_packet_t exp,
                                input fetch_pkg::fetch_packet_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected pc %h inst %h err %0d, got pc %h inst %h err %0d",
               $time, name, exp.pc, exp.inst, exp.err, act.pc, act.inst, act.err);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // Cycles from the PC handshake to the packet handshake
  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("FAILED at %0t: handshake latency expected %0d, got %0d", $time, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out at %0t after %0d cycles waiting for %s", $time, TIMEOUT, what);
  endtask

  // --------------------------------------------------------------------------
  // Drivers
  // --------------------------------------------------------------------------

  // AXI slave serving one single-beat read from a falling edge
  task automatic serve_read(input int ar_stall, input int r_stall,
                            input fetch_pkg::inst_t data, input fetch_pkg::axi_resp_t resp,
                            input logic last, input fetch_pkg::axi_id_t id_xor,
                            output fetch_pkg::addr_t seen_addr,
                            output fetch_pkg::axi_id_t seen_id);
    int wait_cnt;
    wait_cnt = 0;
    while (!arvalid_o && wait_cnt < TIMEOUT) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (!arvalid_o) begin
      report_timeout("arvalid_o");
    end
    seen_addr = araddr_o;
    seen_id = arid_o;
    // Address phase held while the slave stalls
    repeat (ar_stall) begin
      @(negedge clock);
      compare_bit("arvalid_o", 1'b1, arvalid_o);
      compare_addr("araddr_o", seen_addr, araddr_o);
      compare_id("arid_o", seen_id, arid_o);
      compare_bit("pc_ready_o", 1'b0, pc_ready_o);
    end
    arready_i = 1'b1;
    @(negedge clock);
    arready_i = 1'b0;
    repeat (r_stall) begin
      compare_bit("rready_o", 1'b1, rready_o);
      compare_bit("pc_ready_o", 1'b0, pc_ready_o);
      @(negedge clock);
    end
    rvalid_i = 1'b1;
    rdata_i = data;
    rresp_i = resp;
    rlast_i = last;
    // Nonzero mask gives a foreign ID
    rid_i = seen_id ^ id_xor;
    wait_cnt = 0;
    while (!rready_o && wait_cnt < TIMEOUT) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (!rready_o) begin
      report_timeout("rready_o");
    end
    @(negedge clock);
    rvalid_i = 1'b0;
    // Bus garbage once the beat is gone
    rdata_i = $urandom;
    rid_i = $urandom;
  endtask

  // Full fetch of PC offer, bus read and packet taken after pkt_stall cycles
  task automatic fetch_once(input fetch_pkg::addr_t pc, input fetch_pkg::inst_t data,
                            input int ar_stall, input int r_stall, input int pkt_stall,
                            input fetch_pkg::axi_resp_t resp, input logic last,
                            input fetch_pkg::axi_id_t id_xor,
                            input fetch_pkg::fetch_err_t exp_err, output int latency);
    fetch_pkg::addr_t         seen_addr;
    fetch_pkg::axi_id_t       seen_id;
    fetch_pkg::fetch_packet_t exp_pkt;
    int                       wait_cnt;
    int                       t_pc;
    pc_valid_i = 1'b1;
    pc_i = pc;
    wait_cnt = 0;
    while (!pc_ready_o && wait_cnt < TIMEOUT) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (!pc_ready_o) begin
      report_timeout("pc_ready_o");
    end
    t_pc = cycle_cnt;
    @(negedge clock);
    pc_valid_i = 1'b0;
    pc_i = $urandom;
    serve_read(ar_stall, r_stall, data, resp, last, id_xor, seen_addr, seen_id);
    compare_addr("araddr_o", pc, seen_addr);
    compare_id("arid_o", exp_id, seen_id);
    exp_id = exp_id + 1'b1;
    exp_pkt.pc = pc;
    exp_pkt.inst = data;
    exp_pkt.err = exp_err;
    wait_cnt = 0;
    while (!pkt_valid_o && wait_cnt < TIMEOUT) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (!pkt_valid_o) begin
      report_timeout("pkt_valid_o");
    end
    // Packet must hold while decode stalls
    repeat (pkt_stall) begin
      compare_bit("pkt_valid_o", 1'b1, pkt_valid_o);
      compare_packet("pkt_o", exp_pkt, pkt_o);
      compare_bit("rready_o", 1'b0, rready_o);
      compare_bit("pc_ready_o", 1'b0, pc_ready_o);
      @(negedge clock);
    end
    pkt_ready_i = 1'b1;
    compare_packet("pkt_o", exp_pkt, pkt_o);
    latency = cycle_cnt - t_pc;
    @(negedge clock);
    pkt_ready_i = 1'b0;
    compare_bit("pc_ready_o", 1'b1, pc_ready_o);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    compare_bit("pc_ready_o", 1'b1, pc_ready_o);
    compare_bit("arvalid_o", 1'b0, arvalid_o);
    compare_bit("rready_o", 1'b0, rready_o);
    compare_bit("pkt_valid_o", 1'b0, pkt_valid_o);
  endtask

  task automatic test_basic_fetch();
    int latency;
    fetch_once($urandom & 32'hffff_fffc, $urandom, 0, 0, 0, fetch_pkg::RESP_OKAY, 1'b1,
               4'h0, fetch_pkg::ERR_NONE, latency);
    check_latency(3, latency);
  endtask

  task automatic test_back_pressure();
    int latency;
    int ar_stall;
    int r_stall;
    int pkt_stall;
    repeat (8) begin
      ar_stall = $urandom % 5;
      r_stall = $urandom % 5;
      pkt_stall = 1 + $urandom % 5;
      fetch_once($urandom & 32'hffff_fffc, $urandom, ar_stall, r_stall, pkt_stall,
                 fetch_pkg::RESP_OKAY, 1'b1, 4'h0, fetch_pkg::ERR_NONE, latency);
      // Each stall cycle adds exactly one cycle
      check_latency(3 + ar_stall + r_stall + pkt_stall, latency);
    end
  endtask

  // Runs past the 4-bit wrap of the ID counter
  task automatic test_id_sequence();
    int latency;
    repeat (20) begin
      fetch_once($urandom & 32'hffff_fffc, $urandom, 0, 0, 0, fetch_pkg::RESP_OKAY, 1'b1,
                 4'h0, fetch_pkg::ERR_NONE, latency);
      check_latency(3, latency);
    end
  endtask

  task automatic test_error_codes();
    int latency;
    fetch_once($urandom, $urandom, 1, 0, 0, fetch_pkg::RESP_SLVERR, 1'b1, 4'h0,
               fetch_pkg::ERR_BUS, latency);
    check_latency(4, latency);
    // Bus error outranks a foreign ID and a missing last
    fetch_once($urandom, $urandom, 0, 1, 0, fetch_pkg::RESP_DECERR, 1'b0, 4'h9,
               fetch_pkg::ERR_BUS, latency);
    check_latency(4, latency);
    fetch_once($urandom, $urandom, 0, 0, 1, fetch_pkg::RESP_OKAY, 1'b1, 4'h9,
               fetch_pkg::ERR_ID, latency);
    check_latency(4, latency);
    // ID mismatch outranks missing last
    fetch_once($urandom, $urandom, 0, 0, 0, fetch_pkg::RESP_OKAY, 1'b0, 4'h3,
               fetch_pkg::ERR_ID, latency);
    check_latency(3, latency);
    fetch_once($urandom, $urandom, 0, 0, 0, fetch_pkg::RESP_OKAY, 1'b0, 4'h0,
               fetch_pkg::ERR_NO_LAST, latency);
    check_latency(3, latency);
    fetch_once($urandom, $urandom, 0, 0, 0, fetch_pkg::RESP_EXOKAY, 1'b1, 4'h0,
               fetch_pkg::ERR_NONE, latency);
    check_latency(3, latency);
  endtask

  // --------------------------------------------------------------------------
  // Sequence
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h744a));
    reset = 1'b0;
    pc_valid_i = 1'b0;
    pc_i = '0;
    arready_i = 1'b0;
    rvalid_i = 1'b0;
    rdata_i = '0;
    rresp_i = '0;
    rlast_i = 1'b0;
    rid_i = '0;
    pkt_ready_i = 1'b0;
    repeat (5) @(negedge clock);
    reset = 1'b1;
    @(negedge clock);
    test_reset_state();
    test_basic_fetch();
    test_back_pressure();
    test_id_sequence();
    test_error_codes();
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/fetch_pkg.sv
hw/fetch_controller.sv
hw/fetch_request.sv
hw/read_capture.sv
hw/fetch_packer.sv
hw/fetch_unit.sv
sim/tb_fetch_unit.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  # Design, in compile order
  - files:
      - hw/fetch_pkg.sv
      - hw/fetch_controller.sv
      - hw/fetch_request.sv
      - hw/read_capture.sv
      - hw/fetch_packer.sv
      - hw/fetch_unit.sv

  # Testbench, top module tb_fetch_unit
  - target: test
    files:
      - sim/tb_fetch_unit.sv
